// ==== Makefile ====
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        := tb_bomb_game
RTL_TOP    := bomb_game
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
RUN_ARGS   := +verilator+error+limit+1000

.PHONY: lint build sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
hw/bomb_pkg.sv
hw/button_edge_detector.sv
hw/timer_sec_divider.sv
hw/timer_counter.sv
hw/ssdec_spi_master.sv
hw/wire_game.sv
hw/game_control.sv
hw/bomb_game.sv
verif/bomb_game_props.sv
verif/tb_bomb_game.sv

// ==== hw/bomb_game.sv ====
`timescale 1ns/1ps

module bomb_game #(
    parameter int CLK_PER_SEC = 10_000_000,
    parameter int START_MIN   = 2,
    parameter int SCK_HALF    = 7
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [5:0]            button,
    output logic                  ssdec_ss,
    output logic                  ssdec_sck,
    output logic                  ssdec_sdi,
    output bomb_pkg::game_state_t game_state,
    output logic [1:0]            lives,
    output logic [2:0]            wire_pos,
    output logic [5:0]            wire_status
);

    logic [5:0]           btn_edge;
    logic                 strobe;
    logic                 sec_tick;
    bomb_pkg::time_word_t time_word;
    logic                 expired;
    logic                 time_update;
    logic                 timer_clear;
    logic                 activate;
    logic                 armed;
    logic [1:0]           map_select;
    logic                 wire_error;
    logic                 wire_clear;

    button_edge_detector button_edge_detector_0 (
        .clk(clk), .rst_n(rst_n), .button(button),
        .btn_edge(btn_edge), .strobe(strobe)
    );

    timer_sec_divider #(.CLK_PER_SEC(CLK_PER_SEC)) timer_sec_divider_0 (
        .clk(clk), .rst_n(rst_n), .clear(timer_clear), .tick(sec_tick)
    );

    timer_counter #(.START_MIN(START_MIN)) timer_counter_0 (
        .clk(clk), .rst_n(rst_n), .clear(timer_clear), .armed(armed),
        .tick(sec_tick), .time_word(time_word), .expired(expired), .update(time_update)
    );

    ssdec_spi_master #(.SCK_HALF(SCK_HALF)) ssdec_spi_master_0 (
        .clk(clk), .rst_n(rst_n), .time_word(time_word), .update(time_update),
        .ss(ssdec_ss), .sck(ssdec_sck), .sdi(ssdec_sdi)
    );

    game_control game_control_0 (
        .clk(clk), .rst_n(rst_n), .btn_edge(btn_edge), .strobe(strobe),
        .wire_error(wire_error), .wire_clear(wire_clear), .expired(expired),
        .game_state(game_state), .armed(armed), .lives(lives),
        .map_select(map_select), .timer_clear(timer_clear), .activate(activate)
    );

    wire_game wire_game_0 (
        .clk(clk), .rst_n(rst_n), .btn_edge(btn_edge), .strobe(strobe),
        .activate(activate), .armed(armed), .map_select(map_select),
        .wire_pos(wire_pos), .wire_status(wire_status),
        .wire_error(wire_error), .wire_clear(wire_clear)
    );

endmodule

// ==== hw/bomb_pkg.sv ====
package bomb_pkg;

    typedef enum logic [1:0] {
        IDLE,
        ARMED,
        DEFUSED,
        BOOM
    } game_state_t;

    // minutes kept to one digit
    typedef struct packed {
        logic [2:0] minutes;
        logic [2:0] sec_tens;
        logic [3:0] sec_ones;
    } time_digits_t;

    typedef union packed {
        time_digits_t digits;
        logic [9:0]   raw;
    } time_word_t;

    // button vector bit order
    localparam int BTN_SELECT = 0;
    localparam int BTN_UP     = 1;
    localparam int BTN_RIGHT  = 2;
    localparam int BTN_DOWN   = 3;
    localparam int BTN_LEFT   = 4;
    localparam int BTN_BACK   = 5;

    typedef enum logic [2:0] {
        BLACK,
        RED,
        BLUE,
        WHITE,
        YELLOW,
        GREEN
    } wire_colour_t;

    localparam wire_colour_t WIRE_MAPS [4][6] = '{
        '{BLUE,   WHITE, RED,    BLACK, YELLOW, GREEN},
        '{BLACK,  BLUE,  YELLOW, WHITE, RED,    RED},
        '{RED,    GREEN, WHITE,  BLUE,  BLACK,  YELLOW},
        '{YELLOW, BLACK, GREEN,  RED,   BLUE,   WHITE}
    };

    localparam logic [1:0] LIVES_START = 2'd3;

endpackage

// ==== hw/button_edge_detector.sv ====
`timescale 1ns/1ps

module button_edge_detector (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [5:0] button,
    output logic [5:0] btn_edge,
    output logic       strobe
);

    logic [5:0] sync_q1;
    logic [5:0] sync_q2;
    logic [5:0] prev_q;
    logic [5:0] rise;

    // newly pressed since last sample
    assign rise = sync_q2 & ~prev_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1  <= '0;
            sync_q2  <= '0;
            prev_q   <= '0;
            btn_edge <= '0;
            strobe   <= 1'b0;
        end else begin
            sync_q1  <= button;
            sync_q2  <= sync_q1;
            prev_q   <= sync_q2;
            btn_edge <= rise;
            strobe   <= |rise;
        end
    end

endmodule

// ==== hw/game_control.sv ====
`timescale 1ns/1ps

module game_control (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [5:0]            btn_edge,
    input  logic                  strobe,
    input  logic                  wire_error,
    input  logic                  wire_clear,
    input  logic                  expired,
    output bomb_pkg::game_state_t game_state,
    output logic                  armed,
    output logic [1:0]            lives,
    output logic [1:0]            map_select,
    output logic                  timer_clear,
    output logic                  activate
);

    logic start;
    logic back;

    assign start = (game_state == bomb_pkg::IDLE) && strobe
                   && btn_edge[bomb_pkg::BTN_SELECT];
    assign back  = strobe && btn_edge[bomb_pkg::BTN_BACK];

    // timer and puzzle restart on the same edge the round arms
    assign timer_clear = start;
    assign activate    = start;
    assign armed       = (game_state == bomb_pkg::ARMED);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            game_state <= bomb_pkg::IDLE;
            lives      <= bomb_pkg::LIVES_START;
            map_select <= '0;
        end else begin
            case (game_state)
                bomb_pkg::IDLE: begin
                    lives <= bomb_pkg::LIVES_START;
                    if (start) begin
                        game_state <= bomb_pkg::ARMED;
                    end
                end
                bomb_pkg::ARMED: begin
                    if (expired) begin
                        game_state <= bomb_pkg::BOOM;
                    end else if (wire_clear) begin
                        game_state <= bomb_pkg::DEFUSED;
                    end else if (wire_error) begin
                        lives <= lives - 1'b1;
                        if (lives == 2'd1) begin
                            game_state <= bomb_pkg::BOOM;
                        end
                    end
                end
                default: begin
                    // next round gets the next map
                    if (back) begin
                        game_state <= bomb_pkg::IDLE;
                        map_select <= map_select + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// ==== hw/ssdec_spi_master.sv ====
`timescale 1ns/1ps

module ssdec_spi_master #(
    parameter int SCK_HALF = 7
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  bomb_pkg::time_word_t time_word,
    input  logic                 update,
    output logic                 ss,
    output logic                 sck,
    output logic                 sdi
);

    localparam int PW = (SCK_HALF > 0) ? $clog2(SCK_HALF + 1) : 1;

    bomb_pkg::time_word_t word_q;
    logic [PW-1:0]        phase_cnt;
    logic [15:0]          shift_q;
    logic [15:0]          frame_next;
    logic [3:0]           bit_cnt;
    logic                 pending;
    logic                 phase_end;

    assign phase_end  = (phase_cnt == PW'(SCK_HALF));
    assign frame_next = {6'b0, (update ? time_word.raw : word_q.raw)};

    // newest word for a pending frame
    always_ff @(posedge clk) begin
        if (update) begin
            word_q <= time_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ss        <= 1'b1;
            sck       <= 1'b0;
            sdi       <= 1'b0;
            phase_cnt <= '0;
            shift_q   <= '0;
            bit_cnt   <= '0;
            pending   <= 1'b0;
        end else if (ss) begin
            if (update || pending) begin
                ss        <= 1'b0;
                pending   <= 1'b0;
                phase_cnt <= '0;
                bit_cnt   <= '0;
                shift_q   <= frame_next;
                sdi       <= frame_next[15];
            end
        end else begin
            if (update) begin
                pending <= 1'b1;
            end
            if (!phase_end) begin
                phase_cnt <= phase_cnt + 1'b1;
            end else begin
                phase_cnt <= '0;
                sck       <= ~sck;
                // sdi moves on the falling edge only
                if (sck) begin
                    if (bit_cnt == 4'd15) begin
                        ss  <= 1'b1;
                        sdi <= 1'b0;
                    end else begin
                        shift_q <= {shift_q[14:0], 1'b0};
                        sdi     <= shift_q[14];
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== hw/timer_counter.sv ====
`timescale 1ns/1ps

module timer_counter #(
    parameter int START_MIN = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clear,
    input  logic                 armed,
    input  logic                 tick,
    output bomb_pkg::time_word_t time_word,
    output logic                 expired,
    output logic                 update
);

    logic [9:0] prev_raw;

    assign expired = (time_word.raw == 10'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            time_word.raw <= '0;
        end else if (clear) begin
            time_word.digits.minutes  <= 3'(START_MIN);
            time_word.digits.sec_tens <= 3'd0;
            time_word.digits.sec_ones <= 4'd0;
        end else if (armed && tick && !expired) begin
            // borrow ones -> tens -> minutes
            if (time_word.digits.sec_ones != 4'd0) begin
                time_word.digits.sec_ones <= time_word.digits.sec_ones - 1'b1;
            end else if (time_word.digits.sec_tens != 3'd0) begin
                time_word.digits.sec_tens <= time_word.digits.sec_tens - 1'b1;
                time_word.digits.sec_ones <= 4'd9;
            end else begin
                time_word.digits.minutes  <= time_word.digits.minutes - 1'b1;
                time_word.digits.sec_tens <= 3'd5;
                time_word.digits.sec_ones <= 4'd9;
            end
        end
    end

    // refresh request trails each change by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_raw <= '0;
            update   <= 1'b0;
        end else begin
            prev_raw <= time_word.raw;
            update   <= (time_word.raw != prev_raw);
        end
    end

endmodule

// ==== hw/timer_sec_divider.sv ====
`timescale 1ns/1ps

module timer_sec_divider #(
    parameter int CLK_PER_SEC = 10_000_000
) (
    input  logic clk,
    input  logic rst_n,
    input  logic clear,
    output logic tick
);

    localparam int CW = (CLK_PER_SEC > 1) ? $clog2(CLK_PER_SEC) : 1;

    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (clear) begin
            // restart so the first second is full length
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == CW'(CLK_PER_SEC - 1)) begin
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

// ==== hw/wire_game.sv ====
`timescale 1ns/1ps

module wire_game (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [5:0] btn_edge,
    input  logic       strobe,
    input  logic       activate,
    input  logic       armed,
    input  logic [1:0] map_select,
    output logic [2:0] wire_pos,
    output logic [5:0] wire_status,
    output logic       wire_error,
    output logic       wire_clear
);

    logic [1:0] map_q;
    logic [2:0] red_pos;
    logic       press;

    assign press = armed && strobe;

    // lowest-indexed red wire of the active map
    always_comb begin
        red_pos = 3'd0;
        for (int i = 5; i >= 0; i--) begin
            if (bomb_pkg::WIRE_MAPS[map_q][i] == bomb_pkg::RED) begin
                red_pos = 3'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            map_q       <= '0;
            wire_pos    <= '0;
            wire_status <= '0;
            wire_error  <= 1'b0;
            wire_clear  <= 1'b0;
        end else begin
            wire_error <= 1'b0;
            wire_clear <= 1'b0;
            if (activate) begin
                map_q       <= map_select;
                wire_pos    <= '0;
                wire_status <= '0;
            end else if (press) begin
                if (btn_edge[bomb_pkg::BTN_LEFT]) begin
                    wire_pos <= (wire_pos == 3'd0) ? 3'd5 : wire_pos - 1'b1;
                end else if (btn_edge[bomb_pkg::BTN_RIGHT]) begin
                    wire_pos <= (wire_pos == 3'd5) ? 3'd0 : wire_pos + 1'b1;
                end else if (btn_edge[bomb_pkg::BTN_SELECT] && !wire_status[wire_pos]) begin
                    // a wire already cut is ignored
                    wire_status[wire_pos] <= 1'b1;
                    wire_clear            <= (wire_pos == red_pos);
                    wire_error            <= (wire_pos != red_pos);
                end
            end
        end
    end

endmodule

// ==== verif/bomb_game_props.sv ====
`timescale 1ns/1ps

module bomb_game_props (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  ssdec_ss,
    input logic                  ssdec_sck,
    input bomb_pkg::game_state_t game_state,
    input logic [1:0]            lives,
    input logic [5:0]            wire_status,
    input logic                  armed,
    input logic                  time_update,
    input bomb_pkg::time_word_t  time_word
);

    int   fail_count = 0;
    logic update_seen;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            update_seen <= 1'b0;
        end else if (time_update) begin
            update_seen <= 1'b1;
        end
    end

    ss_idle_until_update: assert property (@(posedge clk) disable iff (!rst_n)
        !update_seen |-> ssdec_ss)
    else begin
        fail_count++;
        $error("ss went low before the first display update");
    end

    sck_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
        ssdec_ss |-> !ssdec_sck)
    else begin
        fail_count++;
        $error("sck is high while ss is high");
    end

    lives_no_rise: assert property (@(posedge clk) disable iff (!rst_n)
        (game_state != bomb_pkg::IDLE) |=> (lives <= $past(lives)))
    else begin
        fail_count++;
        $error("lives went up outside IDLE");
    end

    // boom needs no lives left or an empty clock
    boom_entry: assert property (@(posedge clk) disable iff (!rst_n)
        (game_state == bomb_pkg::BOOM && $past(game_state) != bomb_pkg::BOOM)
        |-> (lives == 2'd0 || time_word.raw == 10'd0))
    else begin
        fail_count++;
        $error("BOOM entered with lives and time left");
    end

    cut_status_hold: assert property (@(posedge clk) disable iff (!rst_n)
        armed |=> ((wire_status & $past(wire_status)) == $past(wire_status)))
    else begin
        fail_count++;
        $error("a cut wire came back while armed");
    end

endmodule

bind bomb_game bomb_game_props bomb_game_props_0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .ssdec_ss   (ssdec_ss),
    .ssdec_sck  (ssdec_sck),
    .game_state (game_state),
    .lives      (lives),
    .wire_status(wire_status),
    .armed      (armed),
    .time_update(time_update),
    .time_word  (time_word)
);

// ==== verif/tb_bomb_game.sv ====
`timescale 1ns/1ps

module tb_bomb_game;

    localparam int CLK_PER_SEC  = 20;
    localparam int START_MIN    = 1;
    localparam int SCK_HALF     = 1;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int SEED         = 95429;
    localparam int WANDER_MOVES = 12;
    localparam int START_SECS   = START_MIN * 60;

    // one press is 4 high plus 4 low plus one
    localparam int PRESS_CYCLES    = 9;
    localparam int MAX_PRESSES     = 40;
    localparam int ROUND_CYCLES    = START_SECS * CLK_PER_SEC;
    localparam int FRAME_CYCLES    = 16 * 2 * (SCK_HALF + 1) + 4;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + MAX_PRESSES * PRESS_CYCLES
                                     + ROUND_CYCLES + 4 * FRAME_CYCLES + 200;

    logic                  clk;
    logic                  rst_n;
    logic [5:0]            button;
    logic                  ssdec_ss;
    logic                  ssdec_sck;
    logic                  ssdec_sdi;
    bomb_pkg::game_state_t game_state;
    logic [1:0]            lives;
    logic [2:0]            wire_pos;
    logic [5:0]            wire_status;

    int    errors = 0;
    int    prop_fails;
    string test_name = "none";

    // reference model
    bomb_pkg::game_state_t model_state;
    logic [1:0]            model_lives;
    logic [1:0]            model_next_map;
    logic [1:0]            model_round_map;
    int                    model_pos;
    logic [5:0]            model_status;

    // display frame capture
    logic [15:0] frame_bits;
    int          frame_len;
    int          frame_count = 0;
    int          last_secs   = 0;
    bit          zero_seen   = 1'b0;

    bomb_game #(
        .CLK_PER_SEC(CLK_PER_SEC),
        .START_MIN  (START_MIN),
        .SCK_HALF   (SCK_HALF)
    ) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .button     (button),
        .ssdec_ss   (ssdec_ss),
        .ssdec_sck  (ssdec_sck),
        .ssdec_sdi  (ssdec_sdi),
        .game_state (game_state),
        .lives      (lives),
        .wire_pos   (wire_pos),
        .wire_status(wire_status)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // red positions of the four maps
    function automatic int lowest_red(input logic [1:0] map);
        case (map)
            2'd0:    return 2;
            2'd1:    return 4;
            2'd2:    return 0;
            default: return 3;
        endcase
    endfunction

    task automatic check_value(input string field, input int expected, input int actual);
        assert (actual == expected) else begin
            errors++;
            $display("[ERROR] %s %s: expected %0d, actual %0d",
                     test_name, field, expected, actual);
        end
    endtask

    task automatic check_outputs();
        check_value("game_state", int'(model_state), int'(game_state));
        check_value("lives", int'(model_lives), int'(lives));
        check_value("wire_pos", model_pos, int'(wire_pos));
        check_value("wire_status", int'(model_status), int'(wire_status));
    endtask

    task automatic press_button(input int idx);
        @(posedge clk);
        #2;
        button[idx] = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        button = '0;
        repeat (4) @(posedge clk);
        #2;
    endtask

    task automatic step_model(input int idx);
        case (model_state)
            bomb_pkg::IDLE: begin
                if (idx == bomb_pkg::BTN_SELECT) begin
                    model_state     = bomb_pkg::ARMED;
                    model_pos       = 0;
                    model_status    = '0;
                    model_round_map = model_next_map;
                end
            end
            bomb_pkg::ARMED: begin
                if (idx == bomb_pkg::BTN_LEFT) begin
                    model_pos = (model_pos == 0) ? 5 : model_pos - 1;
                end else if (idx == bomb_pkg::BTN_RIGHT) begin
                    model_pos = (model_pos == 5) ? 0 : model_pos + 1;
                end else if (idx == bomb_pkg::BTN_SELECT && !model_status[model_pos]) begin
                    model_status[model_pos] = 1'b1;
                    if (model_pos == lowest_red(model_round_map)) begin
                        model_state = bomb_pkg::DEFUSED;
                    end else begin
                        model_lives = model_lives - 1'b1;
                        if (model_lives == 2'd0) begin
                            model_state = bomb_pkg::BOOM;
                        end
                    end
                end
            end
            default: begin
                if (idx == bomb_pkg::BTN_BACK) begin
                    model_state    = bomb_pkg::IDLE;
                    model_lives    = bomb_pkg::LIVES_START;
                    model_next_map = model_next_map + 1'b1;
                end
            end
        endcase
    endtask

    task automatic do_press(input int idx);
        press_button(idx);
        step_model(idx);
        check_outputs();
    endtask

    task automatic move_to(input int target);
        while (model_pos != target) begin
            do_press(bomb_pkg::BTN_RIGHT);
        end
    endtask

    task automatic check_frame();
        int mins;
        int tens;
        int ones;
        int secs;
        mins = int'(frame_bits[9:7]);
        tens = int'(frame_bits[6:4]);
        ones = int'(frame_bits[3:0]);
        secs = mins * 60 + tens * 10 + ones;
        frame_count++;
        assert (frame_len == 16) else begin
            errors++;
            $display("[ERROR] display_frames length: expected 16, actual %0d", frame_len);
        end
        assert (frame_bits[15:10] == 6'd0) else begin
            errors++;
            $display("[ERROR] display_frames padding: expected 0, actual %0h",
                     frame_bits[15:10]);
        end
        assert (tens <= 5 && ones <= 9 && secs <= START_SECS) else begin
            errors++;
            $display("[ERROR] display_frames digits: expected m:ss up to %0d:00, actual %0d:%0d%0d",
                     START_MIN, mins, tens, ones);
        end
        if (frame_count == 1) begin
            assert (secs == START_SECS) else begin
                errors++;
                $display("[ERROR] display_frames first frame: expected %0d s, actual %0d s",
                         START_SECS, secs);
            end
        end else begin
            // a new round reloads the start time
            assert (secs < last_secs || secs == START_SECS) else begin
                errors++;
                $display("[ERROR] display_frames order: expected below %0d s, actual %0d s",
                         last_secs, secs);
            end
        end
        if (secs == 0) begin
            zero_seen = 1'b1;
        end
        last_secs = secs;
    endtask

    always @(negedge ssdec_ss) begin
        frame_bits = '0;
        frame_len  = 0;
    end

    always @(posedge ssdec_sck) begin
        if (!ssdec_ss) begin
            frame_bits = {frame_bits[14:0], ssdec_sdi};
            frame_len++;
        end
    end

    always @(posedge ssdec_ss) begin
        if (rst_n) begin
            check_frame();
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int n;
        clk             = 1'b0;
        rst_n           = 1'b0;
        button          = '0;
        model_state     = bomb_pkg::IDLE;
        model_lives     = bomb_pkg::LIVES_START;
        model_next_map  = 2'd0;
        model_round_map = 2'd0;
        model_pos       = 0;
        model_status    = '0;
        void'($urandom(SEED));

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);
        #2;

        test_name = "reset_state";
        check_outputs();
        check_value("ssdec_ss", 1, int'(ssdec_ss));
        check_value("ssdec_sck", 0, int'(ssdec_sck));
        check_value("ssdec_sdi", 0, int'(ssdec_sdi));

        test_name = "cursor_movement";
        do_press(bomb_pkg::BTN_SELECT);
        do_press(bomb_pkg::BTN_LEFT);
        do_press(bomb_pkg::BTN_RIGHT);
        for (int i = 0; i < WANDER_MOVES; i++) begin
            if (($urandom % 2) == 0) begin
                do_press(bomb_pkg::BTN_LEFT);
            end else begin
                do_press(bomb_pkg::BTN_RIGHT);
            end
        end

        test_name = "defusing";
        move_to(lowest_red(model_round_map));
        do_press(bomb_pkg::BTN_SELECT);
        do_press(bomb_pkg::BTN_BACK);

        test_name = "wrong_cuts";
        do_press(bomb_pkg::BTN_SELECT);
        do_press(bomb_pkg::BTN_SELECT);
        // re-cut of the same wire
        do_press(bomb_pkg::BTN_SELECT);
        move_to(1);
        do_press(bomb_pkg::BTN_SELECT);
        move_to(2);
        do_press(bomb_pkg::BTN_SELECT);
        do_press(bomb_pkg::BTN_BACK);

        test_name = "timeout";
        do_press(bomb_pkg::BTN_SELECT);
        n = 0;
        while (game_state != bomb_pkg::BOOM && n < ROUND_CYCLES + 100) begin
            @(posedge clk);
            #2;
            n++;
        end
        model_state = bomb_pkg::BOOM;
        check_outputs();

        test_name = "display_frames";
        n = 0;
        while (!zero_seen && n < 2 * FRAME_CYCLES) begin
            @(posedge clk);
            #2;
            n++;
        end
        check_value("zero frame seen", 1, int'(zero_seen));
        assert (frame_count >= 4) else begin
            errors++;
            $display("[ERROR] display_frames count: expected at least 4, actual %0d",
                     frame_count);
        end

        prop_fails = DUT.bomb_game_props_0.fail_count;
        $display("errors: %0d check failures, %0d assertion failures", errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
